// ==== hdl/mdu_settings.svh ====
/* global sizing for the multiply/divide unit
 * data width, rob tag width and divider iteration count
 */
`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// rv32 data path
`define MDU_XLEN 32

// rob index width, 32 entries
`define MDU_TAG_BITS 5

// one quotient bit per iteration
`define MDU_DIV_STEPS `MDU_XLEN

`endif

// ==== hdl/mdu_pkg.sv ====
/* shared types for the multiply/divide unit
 * widths, funct3 encodings, request and writeback structs, divider states
 */
`default_nettype none

`include "mdu_settings.svh"

package mdu_pkg;

    typedef logic [`MDU_XLEN-1:0]     word_t;   // operand or result
    typedef logic [`MDU_TAG_BITS-1:0] tag_t;    // rob index
    typedef logic [2:0]               funct3_t; // bit 2 set selects the divider

    // M-extension funct3 encodings
    localparam funct3_t FUNCT3_MUL    = 3'b000;
    localparam funct3_t FUNCT3_MULH   = 3'b001; // signed x signed
    localparam funct3_t FUNCT3_MULHSU = 3'b010; // signed x unsigned
    localparam funct3_t FUNCT3_MULHU  = 3'b011; // unsigned x unsigned
    localparam funct3_t FUNCT3_DIV    = 3'b100;
    localparam funct3_t FUNCT3_DIVU   = 3'b101;
    localparam funct3_t FUNCT3_REM    = 3'b110;
    localparam funct3_t FUNCT3_REMU   = 3'b111;

    // incoming op, 72 bits
    typedef struct packed {
        funct3_t funct3;
        word_t   rs1;
        word_t   rs2;
        tag_t    tag;
    } mdu_req_t;

    // result on the writeback port, 37 bits
    typedef struct packed {
        word_t value;
        tag_t  tag;
    } mdu_wb_t;

    // iterative divider sequence
    typedef enum logic [1:0] {
        IDLE, // waiting for an op
        CALC, // shift-subtract steps
        FIX,  // sign correction
        DONE  // result held until taken
    } div_state_e;

endpackage

`default_nettype wire

// ==== hdl/mdu_issue.sv ====
/* issue stage of the multiply/divide unit
 * one request slot, steered to the multiplier or divider by funct3[2]
 */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_issue (
    input  logic             clk_i,
    input  logic             reset_i,
    // from dispatch
    input  logic             req_valid_i,
    output logic             req_ready_o,
    input  mdu_pkg::mdu_req_t req_i,
    // to multiplier
    output logic             mul_valid_o,
    input  logic             mul_ready_i,
    output mdu_pkg::mdu_req_t mul_req_o,
    // to divider
    output logic             div_valid_o,
    input  logic             div_ready_i,
    output mdu_pkg::mdu_req_t div_req_o
);

    mdu_pkg::mdu_req_t req_q; // held request, payload only
    logic              vld_q;
    logic              is_div;
    logic              sel_ready;
    logic              drain;

    assign is_div    = req_q.funct3[2];
    assign sel_ready = is_div ? div_ready_i : mul_ready_i;
    assign drain     = vld_q && sel_ready; // chosen unit takes it this cycle

    assign req_ready_o = !vld_q || drain; // empty or emptying

    assign mul_valid_o = vld_q && !is_div;
    assign div_valid_o = vld_q && is_div;
    assign mul_req_o   = req_q; // same payload to both, only one valid
    assign div_req_o   = req_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vld_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            vld_q <= 1'b1; // refill, back-to-back allowed
        end else if (drain) begin
            vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
    end

    // steering must pick exactly one unit
    a_one_unit: assert property (@(posedge clk_i) disable iff (reset_i)
        !(mul_valid_o && div_valid_o));

endmodule

`default_nettype wire

// ==== hdl/mdu_mul.sv ====
/* two-stage pipelined multiplier for MUL, MULH, MULHSU and MULHU
 * 33x33 signed product with upper or lower word select
 */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_mul (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  mdu_pkg::mdu_req_t req_i,
    output logic              res_valid_o,
    input  logic              res_ready_i,
    output mdu_pkg::mdu_wb_t  res_o
);

    // stage one holds operands extended by a single bit
    typedef struct packed {
        logic [`MDU_XLEN:0] op_a;
        logic [`MDU_XLEN:0] op_b;
        logic               hi_sel; // upper word wanted
        mdu_pkg::tag_t      tag;
    } mul_s1_t;

    // stage two holds the low 64 bits of the product
    typedef struct packed {
        logic [2*`MDU_XLEN-1:0] prod;
        logic                   hi_sel;
        mdu_pkg::tag_t          tag;
    } mul_s2_t;

    mul_s1_t s1_d;
    mul_s1_t s1_q;
    mul_s2_t s2_q;
    logic    s1_vld_q;
    logic    s2_vld_q;
    logic    stall;
    logic signed [2*`MDU_XLEN+1:0] prod_full; // 66 bit signed product

    assign stall       = s2_vld_q && !res_ready_i; // output blocked, freeze all
    assign req_ready_o = !stall;

    // operand extension from funct3
    always_comb begin
        s1_d.tag = req_i.tag;
        case (req_i.funct3)
            mdu_pkg::FUNCT3_MULH: begin
                s1_d.op_a   = {req_i.rs1[`MDU_XLEN-1], req_i.rs1};
                s1_d.op_b   = {req_i.rs2[`MDU_XLEN-1], req_i.rs2};
                s1_d.hi_sel = 1'b1;
            end
            mdu_pkg::FUNCT3_MULHSU: begin
                s1_d.op_a   = {req_i.rs1[`MDU_XLEN-1], req_i.rs1};
                s1_d.op_b   = {1'b0, req_i.rs2}; // rs2 unsigned
                s1_d.hi_sel = 1'b1;
            end
            mdu_pkg::FUNCT3_MULHU: begin
                s1_d.op_a   = {1'b0, req_i.rs1};
                s1_d.op_b   = {1'b0, req_i.rs2};
                s1_d.hi_sel = 1'b1;
            end
            default: begin // MUL, low word same for any signedness
                s1_d.op_a   = {1'b0, req_i.rs1};
                s1_d.op_b   = {1'b0, req_i.rs2};
                s1_d.hi_sel = 1'b0;
            end
        endcase
    end

    assign prod_full = $signed(s1_q.op_a) * $signed(s1_q.op_b);

    // valid bits
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
        end else if (!stall) begin
            s1_vld_q <= req_valid_i;
            s2_vld_q <= s1_vld_q;
        end
    end

    // payload, loaded only with a live op
    always_ff @(posedge clk_i) begin
        if (!stall && req_valid_i) begin
            s1_q <= s1_d;
        end
        if (!stall && s1_vld_q) begin
            s2_q.prod   <= prod_full[2*`MDU_XLEN-1:0];
            s2_q.hi_sel <= s1_q.hi_sel;
            s2_q.tag    <= s1_q.tag;
        end
    end

    assign res_valid_o = s2_vld_q;
    assign res_o.value = s2_q.hi_sel ? s2_q.prod[2*`MDU_XLEN-1:`MDU_XLEN]
                                     : s2_q.prod[`MDU_XLEN-1:0];
    assign res_o.tag   = s2_q.tag;

    // back-pressure freezes both stages
    a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        stall |=> $stable(s1_vld_q) && $stable(s2_vld_q) && $stable(s2_q)
                  && (!s1_vld_q || $stable(s1_q)));

endmodule

`default_nettype wire

// ==== hdl/mdu_div.sv ====
/* iterative radix-2 restoring divider for DIV, DIVU, REM and REMU
 * one op at a time, divide by zero and signed overflow bypass the loop
 */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_div (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  mdu_pkg::mdu_req_t req_i,
    output logic              res_valid_o,
    input  logic              res_ready_i,
    output mdu_pkg::mdu_wb_t  res_o
);

    localparam int CNT_W = $clog2(`MDU_DIV_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MDU_DIV_STEPS - 1);
    localparam mdu_pkg::word_t MOST_NEG = {1'b1, {(`MDU_XLEN-1){1'b0}}};

    mdu_pkg::div_state_e state_q;
    mdu_pkg::div_state_e state_d;

    logic [CNT_W-1:0] cnt_q;     // step counter
    mdu_pkg::word_t   quo_q;     // dividend shifts out, quotient shifts in
    mdu_pkg::word_t   rem_q;     // partial remainder
    mdu_pkg::word_t   divisor_q; // magnitude of rs2
    mdu_pkg::tag_t    tag_q;
    logic             is_rem_q;
    logic             neg_quo_q; // operand signs differ
    logic             neg_rem_q; // follows the dividend

    logic             signed_op;
    logic             a_neg;
    logic             b_neg;
    mdu_pkg::word_t   abs_a;
    mdu_pkg::word_t   abs_b;
    logic             div_zero;
    logic             ovf;
    logic [`MDU_XLEN:0] shifted;
    logic [`MDU_XLEN:0] diff;

    // request decode
    assign signed_op = !req_i.funct3[0]; // DIV and REM
    assign a_neg     = signed_op && req_i.rs1[`MDU_XLEN-1];
    assign b_neg     = signed_op && req_i.rs2[`MDU_XLEN-1];
    assign abs_a     = a_neg ? -req_i.rs1 : req_i.rs1; // MOST_NEG stays as 2^31 unsigned
    assign abs_b     = b_neg ? -req_i.rs2 : req_i.rs2;
    assign div_zero  = (req_i.rs2 == '0);
    assign ovf       = signed_op && (req_i.rs1 == MOST_NEG) && (req_i.rs2 == '1);

    // one restoring step
    assign shifted = {rem_q, quo_q[`MDU_XLEN-1]};
    assign diff    = shifted - {1'b0, divisor_q}; // msb set means borrow

    assign req_ready_o = (state_q == mdu_pkg::IDLE);
    assign res_valid_o = (state_q == mdu_pkg::DONE);
    assign res_o.value = is_rem_q ? rem_q : quo_q;
    assign res_o.tag   = tag_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mdu_pkg::IDLE: begin
                if (req_valid_i) begin
                    state_d = (div_zero || ovf) ? mdu_pkg::FIX : mdu_pkg::CALC;
                end
            end
            mdu_pkg::CALC: begin
                if (cnt_q == LAST_STEP) begin
                    state_d = mdu_pkg::FIX;
                end
            end
            mdu_pkg::FIX: state_d = mdu_pkg::DONE;
            default: begin // DONE
                if (res_ready_i) begin
                    state_d = mdu_pkg::IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= mdu_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            mdu_pkg::IDLE: begin
                if (req_valid_i) begin
                    tag_q    <= req_i.tag;
                    is_rem_q <= req_i.funct3[1];
                    cnt_q    <= '0;
                    if (div_zero) begin
                        quo_q     <= '1;        // all ones quotient
                        rem_q     <= req_i.rs1; // dividend back as remainder
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                    end else if (ovf) begin
                        quo_q     <= req_i.rs1; // MOST_NEG / -1 wraps
                        rem_q     <= '0;
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                    end else begin
                        quo_q     <= abs_a;
                        rem_q     <= '0;
                        divisor_q <= abs_b;
                        neg_quo_q <= a_neg ^ b_neg;
                        neg_rem_q <= a_neg;
                    end
                end
            end
            mdu_pkg::CALC: begin
                cnt_q <= cnt_q + 1'b1;
                rem_q <= diff[`MDU_XLEN] ? shifted[`MDU_XLEN-1:0] : diff[`MDU_XLEN-1:0];
                quo_q <= {quo_q[`MDU_XLEN-2:0], !diff[`MDU_XLEN]};
            end
            mdu_pkg::FIX: begin
                if (neg_quo_q) begin
                    quo_q <= -quo_q;
                end
                if (neg_rem_q) begin
                    rem_q <= -rem_q;
                end
            end
            default: ; // DONE holds the result
        endcase
    end

    // single op in flight, no result pending while ready
    a_ready_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        req_ready_o |-> state_q == mdu_pkg::IDLE && !res_valid_o);

    // restoring steps keep the partial remainder below the divisor
    a_rem_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        state_q == mdu_pkg::CALC |-> rem_q < divisor_q);

endmodule

`default_nettype wire

// ==== hdl/mdu_wb_arbiter.sv ====
/* round-robin writeback arbiter for multiplier and divider results
 * granted result sits in an output register until the port takes it
 */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_wb_arbiter (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             mul_valid_i,
    output logic             mul_ready_o,
    input  mdu_pkg::mdu_wb_t mul_i,
    input  logic             div_valid_i,
    output logic             div_ready_o,
    input  mdu_pkg::mdu_wb_t div_i,
    output logic             wb_valid_o,
    input  logic             wb_ready_i,
    output mdu_pkg::mdu_wb_t wb_o
);

    mdu_pkg::mdu_wb_t wb_q;
    logic             wb_vld_q;
    logic             last_div_q; // divider won the last tie-free grant
    logic             free;
    logic             grant_mul;
    logic             grant_div;

    assign free = !wb_vld_q || wb_ready_i; // empty or draining

    // on contention the loser of last time goes first
    assign grant_mul = free && mul_valid_i && (!div_valid_i || last_div_q);
    assign grant_div = free && div_valid_i && (!mul_valid_i || !last_div_q);

    assign mul_ready_o = grant_mul;
    assign div_ready_o = grant_div;
    assign wb_valid_o  = wb_vld_q;
    assign wb_o        = wb_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_vld_q   <= 1'b0;
            last_div_q <= 1'b0;
        end else begin
            if (grant_mul || grant_div) begin
                wb_vld_q   <= 1'b1;
                last_div_q <= grant_div;
            end else if (wb_ready_i) begin
                wb_vld_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant_mul) begin
            wb_q <= mul_i;
        end else if (grant_div) begin
            wb_q <= div_i;
        end
    end

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        !(grant_mul && grant_div));

    // writeback port holds under back-pressure
    a_wb_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o));

endmodule

`default_nettype wire

// ==== hdl/mdu_top.sv ====
/* multiply/divide execution unit
 * issue slot feeding a pipelined multiplier and an iterative divider
 * with one shared writeback port
 */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  mdu_pkg::mdu_req_t req_i,
    output logic              wb_valid_o,
    input  logic              wb_ready_i,
    output mdu_pkg::mdu_wb_t  wb_o
);

    // issue to units
    logic              mul_req_valid;
    logic              mul_req_ready;
    mdu_pkg::mdu_req_t mul_req;
    logic              div_req_valid;
    logic              div_req_ready;
    mdu_pkg::mdu_req_t div_req;

    // units to arbiter
    logic              mul_res_valid;
    logic              mul_res_ready;
    mdu_pkg::mdu_wb_t  mul_res;
    logic              div_res_valid;
    logic              div_res_ready;
    mdu_pkg::mdu_wb_t  div_res;

    mdu_issue u_issue (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .mul_valid_o (mul_req_valid),
        .mul_ready_i (mul_req_ready),
        .mul_req_o   (mul_req),
        .div_valid_o (div_req_valid),
        .div_ready_i (div_req_ready),
        .div_req_o   (div_req)
    );

    mdu_mul u_mul (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (mul_req_valid),
        .req_ready_o (mul_req_ready),
        .req_i       (mul_req),
        .res_valid_o (mul_res_valid),
        .res_ready_i (mul_res_ready),
        .res_o       (mul_res)
    );

    mdu_div u_div (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (div_req_valid),
        .req_ready_o (div_req_ready),
        .req_i       (div_req),
        .res_valid_o (div_res_valid),
        .res_ready_i (div_res_ready),
        .res_o       (div_res)
    );

    mdu_wb_arbiter u_arb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mul_valid_i (mul_res_valid),
        .mul_ready_o (mul_res_ready),
        .mul_i       (mul_res),
        .div_valid_i (div_res_valid),
        .div_ready_o (div_res_ready),
        .div_i       (div_res),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o)
    );

endmodule

`default_nettype wire

// ==== verif/mdu_tb_model.svh ====
/* reference model for the multiply/divide testbench
 * M-extension results from the ISA rules, plus the random number step
 */
`ifndef MDU_TB_MODEL_SVH
`define MDU_TB_MODEL_SVH

// 32 bit lcg, full period
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// both words widened to 64 bits by their own signedness, product mod 2^64
function automatic mdu_pkg::word_t mul_result(input mdu_pkg::funct3_t f3,
                                              input mdu_pkg::word_t a,
                                              input mdu_pkg::word_t b);
    logic [2*`MDU_XLEN-1:0] wa;
    logic [2*`MDU_XLEN-1:0] wb;
    logic [2*`MDU_XLEN-1:0] p;
    wa = {{`MDU_XLEN{1'b0}}, a};
    wb = {{`MDU_XLEN{1'b0}}, b};
    if (f3 == mdu_pkg::FUNCT3_MULH || f3 == mdu_pkg::FUNCT3_MULHSU) begin
        wa = {{`MDU_XLEN{a[`MDU_XLEN-1]}}, a}; // rs1 signed
    end
    if (f3 == mdu_pkg::FUNCT3_MULH) begin
        wb = {{`MDU_XLEN{b[`MDU_XLEN-1]}}, b};
    end
    p = wa * wb;
    return (f3 == mdu_pkg::FUNCT3_MUL) ? p[`MDU_XLEN-1:0] : p[2*`MDU_XLEN-1:`MDU_XLEN];
endfunction

// signed ops truncate toward zero, remainder keeps the dividend sign
function automatic mdu_pkg::word_t div_result(input mdu_pkg::funct3_t f3,
                                              input mdu_pkg::word_t a,
                                              input mdu_pkg::word_t b);
    logic signed [`MDU_XLEN-1:0] sa;
    logic signed [`MDU_XLEN-1:0] sb;
    logic signed [`MDU_XLEN-1:0] quo_s; // signed quotient
    logic signed [`MDU_XLEN-1:0] rem_s; // signed remainder
    logic                        ovf;
    sa  = a;
    sb  = b;
    ovf = (a == {1'b1, {(`MDU_XLEN-1){1'b0}}}) && (b == '1); // most negative / -1
    quo_s = '0;
    rem_s = '0;
    if (b != '0 && !ovf) begin
        quo_s = sa / sb; // both operands signed here
        rem_s = sa % sb;
    end
    case (f3)
        mdu_pkg::FUNCT3_DIV:  return (b == '0) ? '1 : (ovf ? a : quo_s);
        mdu_pkg::FUNCT3_DIVU: return (b == '0) ? '1 : a / b;
        mdu_pkg::FUNCT3_REM:  return (b == '0) ? a : (ovf ? '0 : rem_s);
        default:              return (b == '0) ? a : a % b; // REMU
    endcase
endfunction

function automatic mdu_pkg::word_t expected_result(input mdu_pkg::funct3_t f3,
                                                   input mdu_pkg::word_t a,
                                                   input mdu_pkg::word_t b);
    return f3[2] ? div_result(f3, a, b) : mul_result(f3, a, b);
endfunction

`endif

// ==== verif/mdu_tb.sv ====
/* testbench for the multiply/divide unit
 * random tagged requests, scoreboard by tag, concurrent assertions check
 */
`timescale 1ns/1ns
`default_nettype none

`include "mdu_settings.svh"

module mdu_tb;

    localparam int NUM_TAGS    = 1 << `MDU_TAG_BITS;
    localparam int RUN_CYCLES  = 4000;
    localparam int STALL_LIMIT = 300;  // no handshake while work is pending
    localparam int DRAIN_LIMIT = 3000;

    logic              clk_i = 1'b0;
    logic              reset_i;
    logic              req_valid_i;
    logic              req_ready_o;
    mdu_pkg::mdu_req_t req_i;
    logic              wb_valid_o;
    logic              wb_ready_i;
    mdu_pkg::mdu_wb_t  wb_o;

    // scoreboard, indexed by tag
    mdu_pkg::word_t    exp_val [NUM_TAGS];
    logic              pending [NUM_TAGS];
    mdu_pkg::funct3_t  op_of [NUM_TAGS];
    int unsigned       acc_seq [NUM_TAGS]; // acceptance order
    mdu_pkg::word_t    exp_now;
    logic              tag_known;
    mdu_pkg::mdu_wb_t  wb_prev;            // last cycle's port, for messages

    logic [31:0]       lcg_state = 32'd91670;
    int                n_out;
    int unsigned       seq;
    int                next_tag;
    int                idle_cycles;
    logic              req_taken;
    logic              wb_taken;
    logic              req_held;           // valid as driven for the next cycle
    logic              timed_out;
    int                op_seen [8];
    int                div_zero_seen;
    int                ovf_seen;
    int                overtakes;          // multiply back before an older divide
    int                value_errors;
    int                tag_errors;
    int                hold_errors;
    int                reset_errors;
    int                other_errors;

    `include "mdu_tb_model.svh"

    mdu_top dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o)
    );

    always #4 clk_i = ~clk_i; // 8 ns period

    always @(posedge clk_i) begin
        wb_prev <= wb_o;
    end

    assign exp_now   = exp_val[wb_o.tag];
    assign tag_known = pending[wb_o.tag];

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_step(lcg_state);
        return lcg_state[31:16]; // upper half, low lcg bits are weak
    endfunction

    // zero, -1, most negative and small values come up often
    function automatic mdu_pkg::word_t pick_operand();
        logic [15:0] r;
        r = next_rand();
        case (r[15:13])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return {1'b1, {(`MDU_XLEN-1){1'b0}}};
            3'd3:    return mdu_pkg::word_t'(r[3:0]);
            default: return {next_rand(), next_rand()};
        endcase
    endfunction

    function automatic mdu_pkg::tag_t find_free_tag();
        int k;
        for (k = 0; k < NUM_TAGS; k++) begin
            if (!pending[(next_tag + k) % NUM_TAGS]) begin
                return mdu_pkg::tag_t'((next_tag + k) % NUM_TAGS);
            end
        end
        return '0; // unreachable while n_out < NUM_TAGS
    endfunction

    // scoreboard update for the handshakes of this edge
    task automatic track_handshakes();
        mdu_pkg::tag_t t;
        int            k;
        req_taken = req_valid_i && req_ready_o;
        wb_taken  = wb_valid_o && wb_ready_i;
        if (wb_taken && pending[wb_o.tag]) begin
            t = wb_o.tag;
            if (!op_of[t][2]) begin
                for (k = 0; k < NUM_TAGS; k++) begin
                    if (pending[k] && op_of[k][2] && acc_seq[k] < acc_seq[t]) begin
                        overtakes++;
                    end
                end
            end
            op_seen[op_of[t]]++;
            pending[t] = 1'b0;
            n_out--;
        end
        if (req_taken) begin
            t          = req_i.tag;
            exp_val[t] = expected_result(req_i.funct3, req_i.rs1, req_i.rs2);
            op_of[t]   = req_i.funct3;
            acc_seq[t] = seq++;
            pending[t] = 1'b1;
            n_out++;
            if (req_i.funct3[2] && req_i.rs2 == '0) begin
                div_zero_seen++;
            end
            if (!req_i.funct3[0] && req_i.funct3[2] && req_i.rs2 == '1
                && req_i.rs1 == {1'b1, {(`MDU_XLEN-1){1'b0}}}) begin
                ovf_seen++;
            end
        end
        if (req_taken || wb_taken || (n_out == 0 && !req_held)) begin
            idle_cycles = 0;
        end else begin
            idle_cycles++;
        end
    endtask

    task automatic drive_inputs(input logic allow_new);
        mdu_pkg::mdu_req_t r;
        logic [15:0]       roll;
        roll = next_rand();
        wb_ready_i <= (roll[15:14] != 2'b00); // back-pressure a quarter of cycles
        if (!req_held || req_taken) begin
            roll = next_rand();
            if (allow_new && n_out < NUM_TAGS && roll[15]) begin
                r.funct3 = roll[14:12];
                r.rs1    = pick_operand();
                r.rs2    = pick_operand();
                r.tag    = find_free_tag();
                next_tag = (int'(r.tag) + 1) % NUM_TAGS;
                req_i       <= r;
                req_valid_i <= 1'b1;
                req_held    = 1'b1;
            end else begin
                req_valid_i <= 1'b0;
                req_held    = 1'b0;
            end
        end
    endtask

    // writeback value against the model
    a_wb_value: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o && wb_ready_i && tag_known |-> wb_o.value == exp_now)
        else begin
            value_errors++;
            $display("CHECK FAILED t=%0t wb_o.value tag %0d got %h expected %h",
                     $time, $sampled(wb_o.tag), $sampled(wb_o.value), $sampled(exp_now));
        end

    // unknown or repeated tag
    a_wb_tag: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o && wb_ready_i |-> tag_known)
        else begin
            tag_errors++;
            $display("CHECK FAILED t=%0t pending[wb_o.tag] tag %0d got 0 expected 1",
                     $time, $sampled(wb_o.tag));
        end

    a_hold_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o)
        else begin
            hold_errors++;
            $display("CHECK FAILED t=%0t wb_valid_o got 0 expected 1", $time);
        end

    a_hold_data: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o && !wb_ready_i |=> $stable(wb_o))
        else begin
            hold_errors++;
            $display("CHECK FAILED t=%0t wb_o got %h expected %h",
                     $time, $sampled(wb_o), $sampled(wb_prev));
        end

    // first cycle out of reset
    a_reset_wb: assert property (@(posedge clk_i) $fell(reset_i) |-> !wb_valid_o)
        else begin
            reset_errors++;
            $display("CHECK FAILED t=%0t wb_valid_o got 1 expected 0", $time);
        end

    a_reset_ready: assert property (@(posedge clk_i) $fell(reset_i) |-> req_ready_o)
        else begin
            reset_errors++;
            $display("CHECK FAILED t=%0t req_ready_o got 0 expected 1", $time);
        end

    initial begin
        int cyc;
        int k;
        int total;
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        wb_ready_i  = 1'b0;
        req_held    = 1'b0;
        req_taken   = 1'b0;
        wb_taken    = 1'b0;
        timed_out   = 1'b0;
        n_out       = 0;
        seq         = 0;
        next_tag    = 0;
        idle_cycles = 0;
        for (k = 0; k < NUM_TAGS; k++) begin
            pending[k] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        // random traffic, watchdog on lack of progress
        for (cyc = 0; cyc < RUN_CYCLES && !timed_out; cyc++) begin
            @(posedge clk_i);
            track_handshakes();
            drive_inputs(1'b1);
            if (idle_cycles > STALL_LIMIT) begin
                $display("no handshake for %0d cycles with work pending at %0t",
                         idle_cycles, $time);
                timed_out = 1'b1;
            end
        end

        // drain, no new requests
        cyc = 0;
        while (!timed_out && (n_out != 0 || req_held)) begin
            @(posedge clk_i);
            track_handshakes();
            drive_inputs(1'b0);
            cyc++;
            if (cyc > DRAIN_LIMIT) begin
                $display("drain did not finish in %0d cycles, %0d tags left", cyc, n_out);
                timed_out = 1'b1;
            end
        end

        // tags whose writeback never came
        for (k = 0; k < NUM_TAGS; k++) begin
            if (pending[k]) begin
                $display("tag %0d still outstanding at end of run", k);
                other_errors++;
            end
        end

        if (timed_out) begin
            other_errors++;
        end else begin
            for (k = 0; k < 8; k++) begin
                if (op_seen[k] == 0) begin
                    $display("funct3 %0d never produced a writeback", k);
                    other_errors++;
                end
            end
            if (div_zero_seen == 0 || ovf_seen == 0) begin
                $display("divide by zero or signed overflow case never issued");
                other_errors++;
            end
            if (overtakes == 0) begin
                $display("no multiply returned ahead of a divide in flight");
                other_errors++;
            end
        end

        total = value_errors + tag_errors + hold_errors + reset_errors + other_errors;
        $display("errors: value %0d tag %0d hold %0d reset %0d other %0d",
                 value_errors, tag_errors, hold_errors, reset_errors, other_errors);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
+incdir+verif
hdl/mdu_pkg.sv
hdl/mdu_issue.sv
hdl/mdu_mul.sv
hdl/mdu_div.sv
hdl/mdu_wb_arbiter.sv
hdl/mdu_top.sv
verif/mdu_tb.sv
